// ==== hw/conv_params.svh ====
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// window geometry
`define CONV_KERN_SZ 3
`define CONV_TAPS 9

// image geometry, one window per output column
`define CONV_IMG_W 6
`define CONV_DEPTH_PAIRS 3
`define CONV_OUT_W 4

// data widths
`define CONV_PIX_W 8
`define CONV_LANE_W 20
`define CONV_ACC_W 24

`endif

// ==== hw/conv_pkg.sv ====
`default_nettype none

`include "conv_params.svh"

package conv_pkg;

  typedef logic [`CONV_PIX_W-1:0] pixel_t;

  // low half feeds lane 0, high half lane 1
  typedef logic [2*`CONV_PIX_W-1:0] pixel_pair_t;

  typedef logic [`CONV_PIX_W-1:0] weight_t;

  typedef logic [$clog2(`CONV_DEPTH_PAIRS*`CONV_KERN_SZ*`CONV_IMG_W)-1:0] img_addr_t;

  typedef logic [$clog2(`CONV_TAPS)-1:0] tap_t;

  typedef logic [$clog2(`CONV_OUT_W)-1:0] col_t;

  typedef logic [`CONV_LANE_W-1:0] lane_sum_t;

  typedef logic [`CONV_ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

// ==== hw/image_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conv_params.svh"

module image_memory (
  input  wire                    clk,
  input  wire                    wr_en,
  input  wire conv_pkg::img_addr_t   wr_addr,
  input  wire conv_pkg::pixel_pair_t wr_data,
  input  wire                    rd_en,
  input  wire conv_pkg::img_addr_t   rd_addr,
  output conv_pkg::pixel_pair_t  rd_data
);

  localparam int WORDS = `CONV_DEPTH_PAIRS * `CONV_KERN_SZ * `CONV_IMG_W;

  // one word per (pair, row, column)
  conv_pkg::pixel_pair_t mem [WORDS];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read register holds its value between reads
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== hw/window_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conv_params.svh"

module window_sequencer (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 start,
  output logic                busy,
  output logic                rd_en,
  output conv_pkg::img_addr_t rd_addr,
  output logic                mac_en,
  output conv_pkg::tap_t      mac_tap,
  output logic                mac_last,
  output conv_pkg::col_t      win_col,
  output logic                win_first_pass,
  output logic                win_final
);

  typedef enum logic {
    IDLE,
    RUN
  } state_t;

  state_t state;

  logic [$clog2(`CONV_DEPTH_PAIRS)-1:0] pair;
  conv_pkg::col_t                       col;
  logic [$clog2(`CONV_KERN_SZ)-1:0]     krow;
  logic [$clog2(`CONV_KERN_SZ)-1:0]     kcol;

  logic last_kcol;
  logic last_krow;
  logic last_tap;
  logic last_col;
  logic last_pair;

  assign last_kcol = (kcol == `CONV_KERN_SZ - 1);
  assign last_krow = (krow == `CONV_KERN_SZ - 1);
  assign last_tap  = last_kcol && last_krow;
  assign last_col  = (col == `CONV_OUT_W - 1);
  assign last_pair = (pair == `CONV_DEPTH_PAIRS - 1);

  assign busy  = (state == RUN);
  assign rd_en = busy;

  // pixel address ((pair * K + row) * W) + column
  assign rd_addr = conv_pkg::img_addr_t'(((pair * `CONV_KERN_SZ + krow) * `CONV_IMG_W)
                                         + col + kcol);

  // counters wrap back to zero on the last read
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      pair  <= '0;
      col   <= '0;
      krow  <= '0;
      kcol  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= RUN;
          end
        end
        RUN: begin
          kcol <= last_kcol ? '0 : kcol + 1'b1;
          if (last_kcol) begin
            krow <= last_krow ? '0 : krow + 1'b1;
          end
          if (last_tap) begin
            col <= last_col ? '0 : col + 1'b1;
          end
          if (last_tap && last_col) begin
            pair <= last_pair ? '0 : pair + 1'b1;
          end
          if (last_tap && last_col && last_pair) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // tags trail the read by one cycle to line up with rd_data
  always_ff @(posedge clk) begin
    if (rst) begin
      mac_en   <= 1'b0;
      mac_last <= 1'b0;
    end else begin
      mac_en   <= busy;
      mac_last <= busy && last_tap;
    end
  end

  always_ff @(posedge clk) begin
    mac_tap        <= conv_pkg::tap_t'(krow * `CONV_KERN_SZ + kcol);
    win_col        <= col;
    win_first_pass <= (pair == '0);
    win_final      <= last_col && last_pair;
  end

endmodule

`default_nettype wire

// ==== hw/conv_lane.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conv_params.svh"

module conv_lane (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   krnl_wr_en,
  input  wire conv_pkg::tap_t   krnl_wr_tap,
  input  wire conv_pkg::weight_t krnl_wr_data,
  input  wire conv_pkg::pixel_t pixel,
  input  wire                   mac_en,
  input  wire conv_pkg::tap_t   mac_tap,
  input  wire                   mac_last,
  output conv_pkg::lane_sum_t   sum,
  output logic                  sum_valid
);

  conv_pkg::weight_t weights [`CONV_TAPS];

  logic [2*`CONV_PIX_W-1:0] product;
  conv_pkg::lane_sum_t      acc;
  conv_pkg::lane_sum_t      acc_next;

  // kernel register file
  always_ff @(posedge clk) begin
    if (krnl_wr_en) begin
      weights[krnl_wr_tap] <= krnl_wr_data;
    end
  end

  assign product = pixel * weights[mac_tap];

  // tap 0 starts a fresh window
  assign acc_next = ((mac_tap == '0) ? '0 : acc) + conv_pkg::lane_sum_t'(product);

  always_ff @(posedge clk) begin
    if (mac_en) begin
      acc <= acc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= mac_en && mac_last;
    end
  end

  // acc still holds the full window while sum_valid is high
  assign sum = acc;

endmodule

`default_nettype wire

// ==== hw/partial_sum_store.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conv_params.svh"

module partial_sum_store (
  input  wire                      clk,
  input  wire                      rst,
  input  wire conv_pkg::lane_sum_t sum0,
  input  wire conv_pkg::lane_sum_t sum1,
  input  wire                      sum_valid,
  input  wire conv_pkg::col_t      win_col,
  input  wire                      win_first_pass,
  input  wire                      win_final,
  input  wire conv_pkg::col_t      res_rd_addr,
  output conv_pkg::acc_t           res_rd_data,
  output logic                     done
);

  conv_pkg::acc_t mem [`CONV_OUT_W];

  conv_pkg::col_t col_q;
  logic           first_q;
  logic           final_q;

  conv_pkg::acc_t acc_base;
  conv_pkg::acc_t acc_new;
  logic           wrote_final;

  // sampled every cycle; in the sum_valid cycle this is the mac_last view
  always_ff @(posedge clk) begin
    col_q   <= win_col;
    first_q <= win_first_pass;
    final_q <= win_final;
  end

  // first depth pass overwrites whatever an earlier run left behind
  assign acc_base = first_q ? '0 : mem[col_q];
  assign acc_new  = acc_base + conv_pkg::acc_t'(sum0) + conv_pkg::acc_t'(sum1);

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      mem[col_q] <= acc_new;
    end
  end

  // host read port
  always_ff @(posedge clk) begin
    res_rd_data <= mem[res_rd_addr];
  end

  // done one edge after the last column's final write
  always_ff @(posedge clk) begin
    if (rst) begin
      wrote_final <= 1'b0;
      done        <= 1'b0;
    end else begin
      wrote_final <= sum_valid && final_q;
      done        <= wrote_final;
    end
  end

endmodule

`default_nettype wire

// ==== hw/conv_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conv_params.svh"

module conv_top (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        img_wr_en,
  input  wire conv_pkg::img_addr_t   img_wr_addr,
  input  wire conv_pkg::pixel_pair_t img_wr_data,
  input  wire                        krnl0_wr_en,
  input  wire                        krnl1_wr_en,
  input  wire conv_pkg::tap_t        krnl_wr_tap,
  input  wire conv_pkg::weight_t     krnl_wr_data,
  input  wire                        start,
  output logic                       busy,
  output logic                       done,
  input  wire conv_pkg::col_t        res_rd_addr,
  output conv_pkg::acc_t             res_rd_data
);

  logic                  rd_en;
  conv_pkg::img_addr_t   rd_addr;
  conv_pkg::pixel_pair_t rd_data;

  logic           mac_en;
  conv_pkg::tap_t mac_tap;
  logic           mac_last;
  conv_pkg::col_t win_col;
  logic           win_first_pass;
  logic           win_final;

  conv_pkg::lane_sum_t sum0;
  conv_pkg::lane_sum_t sum1;
  logic                sum_valid0;

  image_memory img_mem0 (
    .clk     (clk),
    .wr_en   (img_wr_en),
    .wr_addr (img_wr_addr),
    .wr_data (img_wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  window_sequencer seq0 (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .busy           (busy),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .mac_en         (mac_en),
    .mac_tap        (mac_tap),
    .mac_last       (mac_last),
    .win_col        (win_col),
    .win_first_pass (win_first_pass),
    .win_final      (win_final)
  );

  // even channel
  conv_lane lane0 (
    .clk          (clk),
    .rst          (rst),
    .krnl_wr_en   (krnl0_wr_en),
    .krnl_wr_tap  (krnl_wr_tap),
    .krnl_wr_data (krnl_wr_data),
    .pixel        (rd_data[`CONV_PIX_W-1:0]),
    .mac_en       (mac_en),
    .mac_tap      (mac_tap),
    .mac_last     (mac_last),
    .sum          (sum0),
    .sum_valid    (sum_valid0)
  );

  // odd channel in lockstep with lane0
  conv_lane lane1 (
    .clk          (clk),
    .rst          (rst),
    .krnl_wr_en   (krnl1_wr_en),
    .krnl_wr_tap  (krnl_wr_tap),
    .krnl_wr_data (krnl_wr_data),
    .pixel        (rd_data[2*`CONV_PIX_W-1:`CONV_PIX_W]),
    .mac_en       (mac_en),
    .mac_tap      (mac_tap),
    .mac_last     (mac_last),
    .sum          (sum1),
    .sum_valid    ()
  );

  partial_sum_store store0 (
    .clk            (clk),
    .rst            (rst),
    .sum0           (sum0),
    .sum1           (sum1),
    .sum_valid      (sum_valid0),
    .win_col        (win_col),
    .win_first_pass (win_first_pass),
    .win_final      (win_final),
    .res_rd_addr    (res_rd_addr),
    .res_rd_data    (res_rd_data),
    .done           (done)
  );

endmodule

`default_nettype wire

// ==== tb/conv_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "conv_params.svh"

module conv_tb;

  localparam int CLK_HALF = 50;
  localparam int IMG_WORDS = `CONV_DEPTH_PAIRS * `CONV_KERN_SZ * `CONV_IMG_W;
  localparam int READS = `CONV_DEPTH_PAIRS * `CONV_OUT_W * `CONV_TAPS;
  localparam int DONE_LATENCY = READS + 4;
  localparam int QUIET_CYCLES = 20;
  localparam int RUN_CYCLES = DONE_LATENCY + QUIET_CYCLES + IMG_WORDS
                              + 2 * (`CONV_TAPS + 1) + 3 * `CONV_OUT_W + 8;
  localparam int RUNS = 3;
  localparam int TIMEOUT_NS = (RUNS * RUN_CYCLES + 100) * 2 * CLK_HALF;

  logic                  clk;
  logic                  rst;
  logic                  img_wr_en;
  conv_pkg::img_addr_t   img_wr_addr;
  conv_pkg::pixel_pair_t img_wr_data;
  logic                  krnl0_wr_en;
  logic                  krnl1_wr_en;
  conv_pkg::tap_t        krnl_wr_tap;
  conv_pkg::weight_t     krnl_wr_data;
  logic                  start;
  logic                  busy;
  logic                  done;
  conv_pkg::col_t        res_rd_addr;
  conv_pkg::acc_t        res_rd_data;

  // reference copies of what the DUT holds
  conv_pkg::pixel_pair_t img_model [IMG_WORDS];
  conv_pkg::weight_t     k0_model [`CONV_TAPS];
  conv_pkg::weight_t     k1_model [`CONV_TAPS];

  logic [31:0] lfsr;
  logic        started;

  conv_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .img_wr_en    (img_wr_en),
    .img_wr_addr  (img_wr_addr),
    .img_wr_data  (img_wr_data),
    .krnl0_wr_en  (krnl0_wr_en),
    .krnl1_wr_en  (krnl1_wr_en),
    .krnl_wr_tap  (krnl_wr_tap),
    .krnl_wr_data (krnl_wr_data),
    .start        (start),
    .busy         (busy),
    .done         (done),
    .res_rd_addr  (res_rd_addr),
    .res_rd_data  (res_rd_data)
  );

  always #CLK_HALF clk = ~clk;

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic flag_error(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  // taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [`CONV_PIX_W-1:0] random_pixel();
    logic [`CONV_PIX_W-1:0] v;
    v = '0;
    for (int i = 0; i < `CONV_PIX_W; i++) begin
      v = {v[`CONV_PIX_W-2:0], lfsr_bit()};
    end
    return v;
  endfunction

  // sum over depth pairs and taps, both channels
  function automatic int expected_column(input int c);
    int total;
    int addr;
    int tap;
    total = 0;
    for (int p = 0; p < `CONV_DEPTH_PAIRS; p++) begin
      for (int r = 0; r < `CONV_KERN_SZ; r++) begin
        for (int kc = 0; kc < `CONV_KERN_SZ; kc++) begin
          addr = ((p * `CONV_KERN_SZ + r) * `CONV_IMG_W) + c + kc;
          tap = r * `CONV_KERN_SZ + kc;
          total += int'(img_model[addr][`CONV_PIX_W-1:0]) * int'(k0_model[tap]);
          total += int'(img_model[addr][2*`CONV_PIX_W-1:`CONV_PIX_W]) * int'(k1_model[tap]);
        end
      end
    end
    return total;
  endfunction

  task automatic load_image();
    conv_pkg::pixel_pair_t w;
    for (int a = 0; a < IMG_WORDS; a++) begin
      w[`CONV_PIX_W-1:0] = random_pixel();
      w[2*`CONV_PIX_W-1:`CONV_PIX_W] = random_pixel();
      img_model[a] = w;
      @(posedge clk);
      img_wr_en   <= 1'b1;
      img_wr_addr <= conv_pkg::img_addr_t'(a);
      img_wr_data <= w;
    end
    @(posedge clk);
    img_wr_en <= 1'b0;
  endtask

  task automatic load_kernel(input int lane);
    conv_pkg::weight_t w;
    for (int t = 0; t < `CONV_TAPS; t++) begin
      w = random_pixel();
      if (lane == 0) begin
        k0_model[t] = w;
      end else begin
        k1_model[t] = w;
      end
      @(posedge clk);
      krnl0_wr_en  <= (lane == 0);
      krnl1_wr_en  <= (lane == 1);
      krnl_wr_tap  <= conv_pkg::tap_t'(t);
      krnl_wr_data <= w;
    end
    @(posedge clk);
    krnl0_wr_en <= 1'b0;
    krnl1_wr_en <= 1'b0;
  endtask

  // stray_at > 0 pulses a second start that many cycles into the run
  task automatic run_convolution(input int stray_at);
    int n;
    int done_at;
    @(posedge clk);
    start   <= 1'b1;
    started = 1'b1;
    @(posedge clk);
    start <= 1'b0;
    n = 1;
    done_at = 0;
    while (done_at == 0 && n <= DONE_LATENCY + QUIET_CYCLES) begin
      @(negedge clk);
      assert (busy == (n <= READS))
        else flag_error($sformatf("busy is %0b %0d cycles after start", busy, n));
      if (done) begin
        done_at = n;
      end
      @(posedge clk);
      start <= (n == stray_at);
      n++;
    end
    assert (done_at == DONE_LATENCY)
      else flag_error($sformatf("done came %0d cycles after start, expected %0d",
                                done_at, DONE_LATENCY));
    // done is a single pulse and nothing restarts
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      assert (!done && !busy)
        else flag_error("done or busy high after the run finished");
      @(posedge clk);
    end
  endtask

  task automatic check_results();
    int exp;
    for (int c = 0; c < `CONV_OUT_W; c++) begin
      @(posedge clk);
      res_rd_addr <= conv_pkg::col_t'(c);
      @(posedge clk);
      @(negedge clk);
      exp = expected_column(c);
      assert (res_rd_data == conv_pkg::acc_t'(exp))
        else flag_error($sformatf("column %0d is %0d, expected %0d", c, res_rd_data, exp));
    end
  endtask

  always @(negedge clk) begin
    if (!rst && !started) begin
      assert (!busy && !done)
        else flag_error("busy or done high before the first start");
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    abort_run();
  end

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    img_wr_en    = 1'b0;
    img_wr_addr  = '0;
    img_wr_data  = '0;
    krnl0_wr_en  = 1'b0;
    krnl1_wr_en  = 1'b0;
    krnl_wr_tap  = '0;
    krnl_wr_data = '0;
    start        = 1'b0;
    res_rd_addr  = '0;
    lfsr         = 32'h2515a634;
    started      = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    load_image();
    load_kernel(0);
    load_kernel(1);
    run_convolution(0);
    check_results();

    // fresh image and a second start mid run
    load_image();
    run_convolution(40);
    check_results();

    // only lane 1 gets new weights
    load_kernel(1);
    run_convolution(0);
    check_results();

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/conv_pkg.sv
hw/image_memory.sv
hw/window_sequencer.sv
hw/conv_lane.sv
hw/partial_sum_store.sv
hw/conv_top.sv
tb/conv_tb.sv
